// File: cacheBusPkg.sv
`default_nettype none

package cacheBusPkg;

  // load/store request from the pipeline
  typedef struct packed {
    logic                                   isStore;
    cacheGeomPkg::addrFieldsT               addr;
    cacheGeomPkg::wordT                     wrData;
    logic [cacheGeomPkg::MaskWidth-1:0]     wrMask;
  } cpuReqT;

  // dirty victim line going back to memory
  typedef struct packed {
    logic [cacheGeomPkg::AddrWidth-1:0]     addr;
    cacheGeomPkg::lineT                     data;
  } memWbT;

endpackage

`default_nettype wire

// File: cacheController.sv
`timescale 1ns/1ps
`default_nettype none

module cacheController (
  input  logic                               clk,
  input  logic                               rst_n,
  input  cacheBusPkg::cpuReqT                cpuReq_i,
  input  logic                               reqValid_i,
  output logic                               addrOk_o,
  output logic                               dataOk_o,
  input  logic                               hit_i,
  input  logic                               victimDirty_i,
  input  cacheGeomPkg::tagT                  victimTag_i,
  input  cacheGeomPkg::lineT                 victimLine_i,
  input  logic                               rdReady_i,
  input  logic                               wbReady_i,
  input  logic                               memLast_i,
  input  logic                               memDataValid_i,
  output logic                               rdValid_o,
  output logic [cacheGeomPkg::AddrWidth-1:0] rdAddr_o,
  output logic                               wbValid_o,
  output cacheBusPkg::memWbT                 wb_o,
  output cacheGeomPkg::indexT                reqIdx_o,
  output cacheGeomPkg::tagT                  reqTag_o,
  output logic [1:0]                         wordSel_o,
  output logic                               lookup_o,
  output logic                               storeEn_o,
  output cacheGeomPkg::wordT                 storeWord_o,
  output logic [cacheGeomPkg::MaskWidth-1:0] storeMask_o,
  output logic                               refillStart_o,
  output logic                               fillEn_o
);

  import cacheGeomPkg::*;
  import cacheBusPkg::*;

  typedef enum logic [2:0] {
    idle,
    compare,
    writeBack,
    missReq,
    getData,
    replace
  } stateT;

  stateT  stateQ;
  stateT  stateD;
  cpuReqT reqQ;
  logic   accept;
  logic   inCompare;

  assign inCompare = (stateQ == compare);
  assign addrOk_o  = (stateQ == idle) || (inCompare && hit_i && !reqQ.isStore);
  assign accept    = reqValid_i && addrOk_o;

  always_ff @(posedge clk) begin
    if (accept) begin
      reqQ <= cpuReq_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ <= idle;
    end else begin
      stateQ <= stateD;
    end
  end

  always_comb begin
    stateD = stateQ;
    case (stateQ)
      idle: begin
        if (accept) stateD = compare;
      end
      compare: begin
        // a hitting load with a new request stays here
        if (!hit_i) begin
          stateD = victimDirty_i ? writeBack : missReq;
        end else if (!accept) begin
          stateD = idle;
        end
      end
      writeBack: begin
        if (wbReady_i) stateD = missReq;
      end
      missReq: begin
        if (rdReady_i) stateD = getData;
      end
      getData: begin
        if (memDataValid_i && memLast_i) stateD = replace;
      end
      replace:  stateD = compare;
      default:  stateD = idle;
    endcase
  end

  // rams see the incoming index on accept
  assign reqIdx_o  = accept ? cpuReq_i.addr.index : reqQ.addr.index;
  assign reqTag_o  = reqQ.addr.tag;
  assign wordSel_o = reqQ.addr.offset[OffsetWidth-1:OffsetWidth-2];
  assign lookup_o  = accept;
  assign dataOk_o  = inCompare && hit_i;
  assign storeEn_o = inCompare && hit_i && reqQ.isStore;

  // move store data and mask to the byte lane
  assign storeWord_o = reqQ.wrData << {reqQ.addr.offset[2:0], 3'b000};
  assign storeMask_o = reqQ.wrMask << reqQ.addr.offset[2:0];

  assign rdValid_o     = (stateQ == missReq);
  assign rdAddr_o      = {reqQ.addr.tag, reqQ.addr.index, {OffsetWidth{1'b0}}};
  assign refillStart_o = (stateQ == missReq);
  assign fillEn_o      = (stateQ == replace);

  // victim address rebuilt from its stored tag
  assign wbValid_o = (stateQ == writeBack);
  assign wb_o.addr = {victimTag_i, reqQ.addr.index, {OffsetWidth{1'b0}}};
  assign wb_o.data = victimLine_i;

endmodule

`default_nettype wire

// File: cacheGeomPkg.sv
`default_nettype none

package cacheGeomPkg;

  localparam int AddrWidth    = 32;
  localparam int WordWidth    = 64;
  localparam int LineWidth    = 256;
  localparam int WordsPerLine = 4;
  localparam int NumSets      = 64;
  localparam int NumWays      = 2;
  localparam int OffsetWidth  = 5;
  localparam int IndexWidth   = 6;
  localparam int TagWidth     = 21;
  // bytes per pipeline word
  localparam int MaskWidth    = 8;

  typedef logic [TagWidth-1:0]   tagT;
  typedef logic [IndexWidth-1:0] indexT;
  typedef logic [WordWidth-1:0]  wordT;
  typedef logic [LineWidth-1:0]  lineT;
  typedef logic                  wayT;

  // byte address split, msb first
  typedef struct packed {
    tagT                    tag;
    indexT                  index;
    logic [OffsetWidth-1:0] offset;
  } addrFieldsT;

endpackage

`default_nettype wire

// File: dataCache.sv
`timescale 1ns/1ps
`default_nettype none

module dataCache (
  input  logic                               clk,
  input  logic                               rst_n,
  input  cacheBusPkg::cpuReqT                cpuReq_i,
  input  logic                               reqValid_i,
  output logic                               addrOk_o,
  output logic                               dataOk_o,
  output cacheGeomPkg::wordT                 rdData_o,
  output logic                               rdValid_o,
  input  logic                               rdReady_i,
  output logic [cacheGeomPkg::AddrWidth-1:0] rdAddr_o,
  input  cacheGeomPkg::wordT                 memData_i,
  input  logic                               memDataValid_i,
  input  logic                               memLast_i,
  output logic                               wbValid_o,
  input  logic                               wbReady_i,
  output cacheBusPkg::memWbT                 wb_o
);

  import cacheGeomPkg::*;

  logic                 hit;
  wayT                  hitWay;
  wayT                  victimWay;
  logic                 victimDirty;
  tagT                  victimTag;
  lineT                 victimLine;
  lineT                 refillLine;
  indexT                reqIdx;
  tagT                  reqTag;
  logic [1:0]           wordSel;
  logic                 lookup;
  logic                 storeEn;
  wordT                 storeWord;
  logic [MaskWidth-1:0] storeMask;
  logic                 refillStart;
  logic                 fillEn;

  cacheController uCtrl (
    .clk(clk), .rst_n(rst_n), .cpuReq_i(cpuReq_i), .reqValid_i(reqValid_i),
    .addrOk_o(addrOk_o), .dataOk_o(dataOk_o), .hit_i(hit),
    .victimDirty_i(victimDirty), .victimTag_i(victimTag), .victimLine_i(victimLine),
    .rdReady_i(rdReady_i), .wbReady_i(wbReady_i), .memLast_i(memLast_i),
    .memDataValid_i(memDataValid_i), .rdValid_o(rdValid_o), .rdAddr_o(rdAddr_o),
    .wbValid_o(wbValid_o), .wb_o(wb_o), .reqIdx_o(reqIdx), .reqTag_o(reqTag),
    .wordSel_o(wordSel), .lookup_o(lookup), .storeEn_o(storeEn),
    .storeWord_o(storeWord), .storeMask_o(storeMask),
    .refillStart_o(refillStart), .fillEn_o(fillEn)
  );

  tagStore uTags (
    .clk(clk), .rst_n(rst_n), .idx_i(reqIdx), .tag_i(reqTag), .lookup_i(lookup),
    .fill_i(fillEn), .markDirty_i(storeEn), .hit_o(hit), .hitWay_o(hitWay),
    .victimWay_o(victimWay), .victimDirty_o(victimDirty), .victimTag_o(victimTag)
  );

  dataStore uData (
    .clk(clk), .idx_i(reqIdx), .rdEn_i(lookup), .wordSel_i(wordSel),
    .hitWay_i(hitWay), .storeEn_i(storeEn), .storeWord_i(storeWord),
    .storeMask_i(storeMask), .fillEn_i(fillEn), .fillWay_i(victimWay),
    .fillLine_i(refillLine), .rdWord_o(rdData_o), .victimLine_o(victimLine)
  );

  refillBuffer uRefill (
    .clk(clk), .rst_n(rst_n), .start_i(refillStart), .beatValid_i(memDataValid_i),
    .beat_i(memData_i), .line_o(refillLine)
  );

endmodule

`default_nettype wire

// File: dataCache_sva.sv
`timescale 1ns/1ps
`default_nettype none

module dataCache_sva (
  input logic clk,
  input logic rst_n,
  input logic rdValid_o,
  input logic wbValid_o,
  input logic wbReady_i,
  input logic dataOk_o
);

  // write-back and refill read are sequenced, never overlapped
  rdWbExclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(rdValid_o && wbValid_o))
    else $error("read and write-back requested in the same cycle");

  wbHeldUntilReady: assert property (@(posedge clk) disable iff (!rst_n)
    (wbValid_o && !wbReady_i) |=> wbValid_o)
    else $error("write-back request dropped before ready");

  // no data to the pipeline while a refill is pending
  noDataDuringRead: assert property (@(posedge clk) disable iff (!rst_n)
    !(dataOk_o && rdValid_o))
    else $error("data ok raised during a memory read request");

endmodule

bind dataCache dataCache_sva uSva (
  .clk(clk), .rst_n(rst_n), .rdValid_o(rdValid_o), .wbValid_o(wbValid_o),
  .wbReady_i(wbReady_i), .dataOk_o(dataOk_o)
);

`default_nettype wire

// File: dataStore.sv
`timescale 1ns/1ps
`default_nettype none

module dataStore (
  input  logic                               clk,
  input  cacheGeomPkg::indexT                idx_i,
  input  logic                               rdEn_i,
  input  logic [1:0]                         wordSel_i,
  input  cacheGeomPkg::wayT                  hitWay_i,
  input  logic                               storeEn_i,
  input  cacheGeomPkg::wordT                 storeWord_i,
  input  logic [cacheGeomPkg::MaskWidth-1:0] storeMask_i,
  input  logic                               fillEn_i,
  input  cacheGeomPkg::wayT                  fillWay_i,
  input  cacheGeomPkg::lineT                 fillLine_i,
  output cacheGeomPkg::wordT                 rdWord_o,
  output cacheGeomPkg::lineT                 victimLine_o
);

  import cacheGeomPkg::*;

  wordT bitMask;
  lineT storeBits;
  lineT wrLine;
  lineT bitEn;
  lineT wayLine [NumWays];
  lineT hitLine;

  // byte mask to bit enables
  always_comb begin
    for (int b = 0; b < MaskWidth; b++) begin
      bitMask[b*8 +: 8] = {8{storeMask_i[b]}};
    end
  end

  // place them on the addressed word
  always_comb begin
    storeBits = '0;
    storeBits[wordSel_i*WordWidth +: WordWidth] = bitMask;
  end

  assign wrLine = fillEn_i ? fillLine_i : {WordsPerLine{storeWord_i}};
  assign bitEn  = fillEn_i ? '1 : storeBits;

  for (genvar w = 0; w < NumWays; w++) begin : gWay
    logic wayWe;

    assign wayWe = (fillEn_i && (fillWay_i == wayT'(w)))
                || (storeEn_i && (hitWay_i == wayT'(w)));

    lineRam #(
      .entryT(lineT),
      .Depth (NumSets)
    ) uDataRam (
      .clk     (clk),
      .en_i    (rdEn_i || wayWe),
      .we_i    (wayWe),
      .addr_i  (idx_i),
      .bitEn_i (bitEn),
      .wrData_i(wrLine),
      .rdData_o(wayLine[w])
    );
  end

  assign hitLine = wayLine[hitWay_i];

  // a store returns zero on the read bus
  assign rdWord_o     = storeEn_i ? '0 : hitLine[wordSel_i*WordWidth +: WordWidth];
  assign victimLine_o = wayLine[fillWay_i];

endmodule

`default_nettype wire

// File: lineRam.sv
`timescale 1ns/1ps
`default_nettype none

module lineRam #(
  parameter type entryT = logic [7:0],
  parameter int  Depth  = 64
) (
  input  logic                     clk,
  input  logic                     en_i,
  input  logic                     we_i,
  input  logic [$clog2(Depth)-1:0] addr_i,
  input  entryT                    bitEn_i,
  input  entryT                    wrData_i,
  output entryT                    rdData_o
);

  entryT mem [Depth];
  entryT merged;

  // only enabled bits take the new value
  assign merged = (mem[addr_i] & ~bitEn_i) | (wrData_i & bitEn_i);

  // registered read, write-first so a fill is visible on the next cycle
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= merged;
        rdData_o    <= merged;
      end else begin
        rdData_o <= mem[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

// File: refillBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module refillBuffer (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start_i,
  input  logic               beatValid_i,
  input  cacheGeomPkg::wordT beat_i,
  output cacheGeomPkg::lineT line_o
);

  import cacheGeomPkg::*;

  logic [$clog2(WordsPerLine)-1:0] beatCnt;

  // beat position within the line
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (start_i) begin
      beatCnt <= '0;
    end else if (beatValid_i) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  // first beat lands in word 0
  always_ff @(posedge clk) begin
    if (beatValid_i) begin
      line_o[beatCnt*WordWidth +: WordWidth] <= beat_i;
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_dataCache -f sources.f -o simv \
  || { echo "build failed"; exit 1; }
./obj_dir/simv 2>&1 | tee sim.log
grep -q "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: sources.f
cacheGeomPkg.sv
cacheBusPkg.sv
lineRam.sv
tagStore.sv
dataStore.sv
refillBuffer.sv
cacheController.sv
dataCache.sv
dataCache_sva.sv
tb_dataCache.sv

// File: tagStore.sv
`timescale 1ns/1ps
`default_nettype none

module tagStore (
  input  logic               clk,
  input  logic               rst_n,
  input  cacheGeomPkg::indexT idx_i,
  input  cacheGeomPkg::tagT  tag_i,
  input  logic               lookup_i,
  input  logic               fill_i,
  input  logic               markDirty_i,
  output logic               hit_o,
  output cacheGeomPkg::wayT  hitWay_o,
  output cacheGeomPkg::wayT  victimWay_o,
  output logic               victimDirty_o,
  output cacheGeomPkg::tagT  victimTag_o
);

  import cacheGeomPkg::*;

  logic [NumWays-1:0][NumSets-1:0] validQ;
  logic [NumWays-1:0][NumSets-1:0] dirtyQ;
  logic [NumSets-1:0]              rrQ;
  indexT                           idxQ;
  tagT                             tagQ [NumWays];
  logic [NumWays-1:0]              wayHit;

  // set under compare, follows the ram read
  always_ff @(posedge clk) begin
    if (lookup_i) begin
      idxQ <= idx_i;
    end
  end

  for (genvar w = 0; w < NumWays; w++) begin : gWay
    logic wayWe;

    assign wayWe = fill_i && (victimWay_o == wayT'(w));

    lineRam #(
      .entryT(tagT),
      .Depth (NumSets)
    ) uTagRam (
      .clk     (clk),
      .en_i    (lookup_i || fill_i),
      .we_i    (wayWe),
      .addr_i  (idx_i),
      .bitEn_i ('1),
      .wrData_i(tag_i),
      .rdData_o(tagQ[w])
    );

    assign wayHit[w] = validQ[w][idxQ] && (tagQ[w] == tag_i);
  end

  assign hit_o    = |wayHit;
  assign hitWay_o = wayHit[1];

  // invalid way first, then the round-robin pick
  assign victimWay_o   = !validQ[0][idxQ] ? 1'b0 :
                         !validQ[1][idxQ] ? 1'b1 : rrQ[idxQ];
  assign victimDirty_o = dirtyQ[victimWay_o][idxQ];
  assign victimTag_o   = tagQ[victimWay_o];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= '0;
      dirtyQ <= '0;
      rrQ    <= '0;
    end else if (fill_i) begin
      validQ[victimWay_o][idxQ] <= 1'b1;
      dirtyQ[victimWay_o][idxQ] <= 1'b0;
      rrQ[idxQ]                 <= ~rrQ[idxQ];
    end else if (markDirty_i) begin
      dirtyQ[hitWay_o][idxQ] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: tb_dataCache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dataCache;

  import cacheGeomPkg::*;
  import cacheBusPkg::*;

  localparam int NumTests   = 12;
  localparam int CycleLimit = NumTests * 40 + 100;

  typedef struct packed {
    logic                 isStore;
    logic [AddrWidth-1:0] addr;
    wordT                 data;
    logic [MaskWidth-1:0] mask;
    logic                 expMiss;
    logic                 expWb;
    logic [AddrWidth-1:0] wbAddr;
  } testT;

  logic clk;
  logic rst_n;
  cpuReqT cpuReq_i;
  logic reqValid_i, addrOk_o, dataOk_o;
  wordT rdData_o, memData_i;
  logic rdValid_o, rdReady_i, memDataValid_i, memLast_i, wbValid_o, wbReady_i;
  logic [AddrWidth-1:0] rdAddr_o;
  memWbT wb_o;

  testT tests [NumTests];
  wordT expVal [NumTests];
  wordT memModel [logic [31:0]];
  wordT shadow [logic [31:0]];
  int unsigned lcgState = 28112;
  int errors = 0;
  int passCount = 0;
  int cycleCnt = 0;
  int rdCount = 0;
  int wbCount = 0;
  logic [31:0] lastRdAddr = '0;
  logic [31:0] lastWbAddr = '0;
  logic wbHeld = 1'b0;

  dataCache dut_i (
    .clk(clk), .rst_n(rst_n), .cpuReq_i(cpuReq_i), .reqValid_i(reqValid_i),
    .addrOk_o(addrOk_o), .dataOk_o(dataOk_o), .rdData_o(rdData_o),
    .rdValid_o(rdValid_o), .rdReady_i(rdReady_i), .rdAddr_o(rdAddr_o),
    .memData_i(memData_i), .memDataValid_i(memDataValid_i), .memLast_i(memLast_i),
    .wbValid_o(wbValid_o), .wbReady_i(wbReady_i), .wb_o(wb_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic int unsigned nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState >> 16;
  endfunction

  // initial memory content, address high and its inverse low
  function automatic wordT patternWord(input logic [31:0] a);
    return {a, ~a};
  endfunction

  task automatic checkValue(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // memory side, random ready stalls of 0 to 3 cycles
  initial begin : memoryModel
    int stall;
    logic [31:0] base;
    lineT line;
    rdReady_i = 1'b0;
    wbReady_i = 1'b0;
    memData_i = '0;
    memDataValid_i = 1'b0;
    memLast_i = 1'b0;
    forever begin
      @(negedge clk);
      if (wbValid_o) begin
        base = wb_o.addr;
        line = wb_o.data;
        stall = int'(nextRand() % 4);
        repeat (stall) @(posedge clk);
        @(posedge clk);
        wbReady_i <= 1'b1;
        @(posedge clk);
        wbReady_i <= 1'b0;
        for (int b = 0; b < WordsPerLine; b++) begin
          memModel[base + 32'(b * 8)] = line[b*WordWidth +: WordWidth];
        end
        wbCount++;
        lastWbAddr = base;
      end else if (rdValid_o) begin
        base = rdAddr_o;
        stall = int'(nextRand() % 4);
        repeat (stall) @(posedge clk);
        @(posedge clk);
        rdReady_i <= 1'b1;
        @(posedge clk);
        rdReady_i <= 1'b0;
        rdCount++;
        lastRdAddr = base;
        // beats in word order, last one flagged
        for (int b = 0; b < WordsPerLine; b++) begin
          memData_i <= memModel.exists(base + 32'(b * 8)) ? memModel[base + 32'(b * 8)]
                                                          : patternWord(base + 32'(b * 8));
          memDataValid_i <= 1'b1;
          memLast_i <= (b == WordsPerLine - 1);
          @(posedge clk);
        end
        memDataValid_i <= 1'b0;
        memLast_i <= 1'b0;
      end
    end
  end

  // memory protocol, seen from the testbench
  always @(negedge clk) begin
    if (rst_n) begin
      checkValue("read and write-back overlap", 64'(rdValid_o && wbValid_o), 64'd0);
      checkValue("data ok during read", 64'(dataOk_o && rdValid_o), 64'd0);
      checkValue("write-back dropped early", 64'(wbHeld && !wbValid_o), 64'd0);
      wbHeld = wbValid_o && !wbReady_i;
    end
  end

  always @(posedge clk) begin
    cycleCnt++;
    if (cycleCnt > CycleLimit) begin
      $display("timeout: the run did not finish within %0d cycles", CycleLimit);
      $display("tests failed");
      $finish;
    end
  end

  task automatic applyTest(input int i);
    testT t;
    cpuReqT req;
    int errBefore, rdBefore, wbBefore, lat;
    t = tests[i];
    errBefore = errors;
    rdBefore = rdCount;
    wbBefore = wbCount;
    req.isStore = t.isStore;
    req.addr = t.addr;
    req.wrData = t.data;
    req.wrMask = t.mask;
    @(posedge clk);
    reqValid_i <= 1'b1;
    cpuReq_i <= req;
    @(negedge clk);
    while (!addrOk_o) @(negedge clk);
    @(posedge clk);
    reqValid_i <= 1'b0;
    lat = 1;
    @(negedge clk);
    while (!dataOk_o) begin
      lat++;
      @(negedge clk);
    end
    checkValue("read data", rdData_o, expVal[i]);
    if (t.expMiss) begin
      checkValue("line reads", 64'(rdCount - rdBefore), 64'd1);
      checkValue("read address", 64'(lastRdAddr), 64'({t.addr[31:5], 5'b00000}));
    end else begin
      checkValue("hit latency", 64'(lat), 64'd1);
    end
    checkValue("write-backs", 64'(wbCount - wbBefore), 64'(t.expWb));
    if (t.expWb) checkValue("write-back address", 64'(lastWbAddr), 64'(t.wbAddr));
    if (errors == errBefore) passCount++;
    $display("test %0d %s %h: %s", i, t.isStore ? "store" : "load", t.addr,
             (errors == errBefore) ? "ok" : "mismatch");
  endtask

  initial begin : main
    logic [31:0] a;
    wordT w;
    rst_n = 1'b0;
    reqValid_i = 1'b0;
    cpuReq_i = '0;
    // op, address, data, mask, miss, write-back, write-back address
    tests[0]  = '{1'b0, 32'h0000_0100, 64'h0, 8'h00, 1'b1, 1'b0, 32'h0};
    tests[1]  = '{1'b0, 32'h0000_0108, 64'h0, 8'h00, 1'b0, 1'b0, 32'h0};
    tests[2]  = '{1'b1, 32'h0000_0110, 64'h1122_3344_5566_7788, 8'h0F, 1'b0, 1'b0, 32'h0};
    tests[3]  = '{1'b0, 32'h0000_0110, 64'h0, 8'h00, 1'b0, 1'b0, 32'h0};
    tests[4]  = '{1'b1, 32'h0000_0208, 64'hA5A5_0000_FFFF_1234, 8'hF0, 1'b1, 1'b0, 32'h0};
    tests[5]  = '{1'b0, 32'h0000_0208, 64'h0, 8'h00, 1'b0, 1'b0, 32'h0};
    // three tags on set 3
    tests[6]  = '{1'b1, 32'h0001_0060, 64'hDEAD_BEEF_0BAD_F00D, 8'hFF, 1'b1, 1'b0, 32'h0};
    tests[7]  = '{1'b0, 32'h0002_0068, 64'h0, 8'h00, 1'b1, 1'b0, 32'h0};
    tests[8]  = '{1'b0, 32'h0003_0070, 64'h0, 8'h00, 1'b1, 1'b1, 32'h0001_0060};
    tests[9]  = '{1'b0, 32'h0001_0060, 64'h0, 8'h00, 1'b1, 1'b0, 32'h0};
    tests[10] = '{1'b0, 32'h0003_0078, 64'h0, 8'h00, 1'b0, 1'b0, 32'h0};
    tests[11] = '{1'b0, 32'h0000_0118, 64'h0, 8'h00, 1'b0, 1'b0, 32'h0};
    // expected loads from the shadow memory, stores read back zero
    for (int i = 0; i < NumTests; i++) begin
      a = {tests[i].addr[31:3], 3'b000};
      w = shadow.exists(a) ? shadow[a] : patternWord(a);
      if (tests[i].isStore) begin
        for (int b = 0; b < MaskWidth; b++) begin
          if (tests[i].mask[b]) w[b*8 +: 8] = tests[i].data[b*8 +: 8];
        end
        shadow[a] = w;
        expVal[i] = '0;
      end else begin
        expVal[i] = w;
      end
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    checkValue("rdValid after reset", 64'(rdValid_o), 64'd0);
    checkValue("wbValid after reset", 64'(wbValid_o), 64'd0);
    checkValue("dataOk after reset", 64'(dataOk_o), 64'd0);
    checkValue("addrOk after reset", 64'(addrOk_o), 64'd1);
    if (errors == 0) passCount++;
    $display("test reset: %s", (errors == 0) ? "ok" : "mismatch");
    for (int i = 0; i < NumTests; i++) applyTest(i);
    $display("%0d of %0d tests ok, %0d errors", passCount, NumTests + 1, errors);
    if (errors == 0) $display("all tests passed");
    else $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire
